//--- verilog/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int WORD_ADDR_W = 30;

    localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013; // addi x0,x0,0

    // kept major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_XOR = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRA = 4'd7,
        ALU_SRL = 4'd8
    } alu_op_e;

    typedef struct packed {
        logic    regwrite;
        logic    memtoreg; // writeback takes load data
        logic    memread;
        logic    memwrite;
        logic    alusrc;   // operand b is the immediate
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                  regwrite;
        logic                  memtoreg;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       load_data;
    } mem_wb_t;

    typedef struct packed {
        logic                  regwrite;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

    // both cache ports carry words with the byte order reversed
    function automatic logic [XLEN-1:0] byte_swap(input logic [XLEN-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

`default_nettype wire

//--- verilog/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire rv_core_pkg::wb_t                    i_wb,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  i_rs1_addr,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  i_rs2_addr,
    output      logic [rv_core_pkg::XLEN-1:0]        o_rs1_data,
    output      logic [rv_core_pkg::XLEN-1:0]        o_rs2_data
);

    logic [rv_core_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.regwrite && (i_wb.rd != '0)) begin
            regs[i_wb.rd] <= i_wb.data; // x0 stays zero
        end
    end

    assign o_rs1_data = regs[i_rs1_addr];
    assign o_rs2_data = regs[i_rs2_addr];

endmodule

`default_nettype wire

//--- verilog/rv_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic [rv_core_pkg::XLEN-1:0]         i_icache_rdata,
    input  wire logic                                 i_icache_stall,
    input  wire logic                                 i_dcache_stall,
    input  wire logic                                 i_load_use,
    output      logic [rv_core_pkg::WORD_ADDR_W-1:0]  o_icache_addr,
    output      logic [rv_core_pkg::XLEN-1:0]         o_pc,
    output      logic [rv_core_pkg::XLEN-1:0]         o_inst
);

    logic [rv_core_pkg::XLEN-1:0] pc_q;
    logic [rv_core_pkg::XLEN-1:0] inst_q; // IF/ID word

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q   <= '0;
            inst_q <= rv_core_pkg::NOP_INST;
        end else if (i_dcache_stall || i_load_use) begin
            pc_q   <= pc_q; // whole front end waits
            inst_q <= inst_q;
        end else if (i_icache_stall) begin
            inst_q <= rv_core_pkg::NOP_INST; // pc stays, feed a bubble
        end else begin
            pc_q   <= pc_q + 32'd4;
            inst_q <= rv_core_pkg::byte_swap(i_icache_rdata);
        end
    end

    assign o_icache_addr = pc_q[rv_core_pkg::XLEN-1:2]; // word address
    assign o_pc          = pc_q;
    assign o_inst        = inst_q;

endmodule

`default_nettype wire

//--- verilog/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic [rv_core_pkg::XLEN-1:0]  i_inst,
    input  wire rv_core_pkg::wb_t              i_wb,
    input  wire logic                          i_dcache_stall,
    output      rv_core_pkg::id_ex_t           o_id_ex,
    output      logic                          o_load_use
);

    logic [6:0]                        opcode;
    logic [2:0]                        funct3;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_core_pkg::XLEN-1:0]      imm_i;
    logic [rv_core_pkg::XLEN-1:0]      imm_s;
    logic [rv_core_pkg::XLEN-1:0]      imm;
    logic [rv_core_pkg::XLEN-1:0]      rf_rs1_data;
    logic [rv_core_pkg::XLEN-1:0]      rf_rs2_data;
    logic [rv_core_pkg::XLEN-1:0]      rs1_data;
    logic [rv_core_pkg::XLEN-1:0]      rs2_data;
    logic                              uses_rs1;
    logic                              uses_rs2;
    rv_core_pkg::alu_op_e              alu_sel;
    rv_core_pkg::ctrl_t                ctrl;

    // ID/EX register
    rv_core_pkg::ctrl_t                ctrl_q;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_q;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_q;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rd_q;
    logic [rv_core_pkg::XLEN-1:0]      rs1_data_q;
    logic [rv_core_pkg::XLEN-1:0]      rs2_data_q;
    logic [rv_core_pkg::XLEN-1:0]      imm_q;

    assign opcode = i_inst[6:0];
    assign rd     = i_inst[11:7];
    assign funct3 = i_inst[14:12];
    assign rs1    = i_inst[19:15];
    assign rs2    = i_inst[24:20];
    assign imm_i  = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s  = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};

    // funct7 bit 30 picks sub only for register ops, sra for both
    always_comb begin
        case (funct3)
            3'b000:  alu_sel = (i_inst[30] && (opcode == rv_core_pkg::OPC_OP)) ?
                               rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001:  alu_sel = rv_core_pkg::ALU_SLL;
            3'b010:  alu_sel = rv_core_pkg::ALU_SLT;
            3'b100:  alu_sel = rv_core_pkg::ALU_XOR;
            3'b101:  alu_sel = i_inst[30] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  alu_sel = rv_core_pkg::ALU_OR;
            3'b111:  alu_sel = rv_core_pkg::ALU_AND;
            default: alu_sel = rv_core_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl     = '0;
        imm      = imm_i;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                ctrl.regwrite = 1'b1;
                ctrl.alu_op   = alu_sel;
                uses_rs2      = 1'b1;
            end
            rv_core_pkg::OPC_OP_IMM: begin
                ctrl.regwrite = 1'b1;
                ctrl.alusrc   = 1'b1;
                ctrl.alu_op   = alu_sel;
            end
            rv_core_pkg::OPC_LOAD: begin
                ctrl.regwrite = 1'b1;
                ctrl.memtoreg = 1'b1;
                ctrl.memread  = 1'b1;
                ctrl.alusrc   = 1'b1; // address = rs1 + imm
            end
            rv_core_pkg::OPC_STORE: begin
                ctrl.memwrite = 1'b1;
                ctrl.alusrc   = 1'b1;
                imm           = imm_s;
                uses_rs2      = 1'b1;
            end
            default: uses_rs1 = 1'b0; // unsupported, behaves as nop
        endcase
    end

    rv_regfile u_rv_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wb       (i_wb),
        .i_rs1_addr (rs1),
        .i_rs2_addr (rs2),
        .o_rs1_data (rf_rs1_data),
        .o_rs2_data (rf_rs2_data)
    );

    // write-first bypass of the value being written this cycle
    assign rs1_data = (i_wb.regwrite && (i_wb.rd != '0) && (i_wb.rd == rs1)) ?
                      i_wb.data : rf_rs1_data;
    assign rs2_data = (i_wb.regwrite && (i_wb.rd != '0) && (i_wb.rd == rs2)) ?
                      i_wb.data : rf_rs2_data;

    // load in EX whose result is needed right now
    assign o_load_use = ctrl_q.memread && (rd_q != '0) &&
                        ((uses_rs1 && (rd_q == rs1)) || (uses_rs2 && (rd_q == rs2)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
            rs1_q  <= '0;
            rs2_q  <= '0;
            rd_q   <= '0;
        end else if (!i_dcache_stall) begin
            ctrl_q <= o_load_use ? '0 : ctrl; // bubble
            rs1_q  <= rs1;
            rs2_q  <= rs2;
            rd_q   <= rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_dcache_stall) begin
            rs1_data_q <= rs1_data;
            rs2_data_q <= rs2_data;
            imm_q      <= imm;
        end
    end

    assign o_id_ex = '{ctrl: ctrl_q, rs1: rs1_q, rs2: rs2_q, rd: rd_q,
                       rs1_data: rs1_data_q, rs2_data: rs2_data_q, imm: imm_q};

endmodule

`default_nettype wire

//--- verilog/rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire rv_core_pkg::id_ex_t  i_id_ex,
    input  wire rv_core_pkg::wb_t     i_wb,
    input  wire logic                 i_dcache_stall,
    output      rv_core_pkg::ex_mem_t o_ex_mem
);

    logic                         mem_hit1;
    logic                         mem_hit2;
    logic                         wb_hit1;
    logic                         wb_hit2;
    logic [rv_core_pkg::XLEN-1:0] op_a;
    logic [rv_core_pkg::XLEN-1:0] rs2_fwd;
    logic [rv_core_pkg::XLEN-1:0] op_b;
    logic [4:0]                   shamt;
    logic [rv_core_pkg::XLEN-1:0] alu_out;

    // EX/MEM register
    rv_core_pkg::ctrl_t                 ctrl_q;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rd_q;
    logic [rv_core_pkg::XLEN-1:0]       alu_q;
    logic [rv_core_pkg::XLEN-1:0]       store_q;

    assign mem_hit1 = ctrl_q.regwrite && (rd_q != '0) && (rd_q == i_id_ex.rs1);
    assign mem_hit2 = ctrl_q.regwrite && (rd_q != '0) && (rd_q == i_id_ex.rs2);
    assign wb_hit1  = i_wb.regwrite && (i_wb.rd != '0) && (i_wb.rd == i_id_ex.rs1);
    assign wb_hit2  = i_wb.regwrite && (i_wb.rd != '0) && (i_wb.rd == i_id_ex.rs2);

    // newest producer wins
    always_comb begin
        if (mem_hit1) begin
            op_a = alu_q;
        end else if (wb_hit1) begin
            op_a = i_wb.data;
        end else begin
            op_a = i_id_ex.rs1_data;
        end
    end

    always_comb begin
        if (mem_hit2) begin
            rs2_fwd = alu_q;
        end else if (wb_hit2) begin
            rs2_fwd = i_wb.data;
        end else begin
            rs2_fwd = i_id_ex.rs2_data;
        end
    end

    assign op_b  = i_id_ex.ctrl.alusrc ? i_id_ex.imm : rs2_fwd;
    assign shamt = op_b[4:0]; // imm bit 30 of srai must not count

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            rv_core_pkg::ALU_SUB: alu_out = op_a - op_b;
            rv_core_pkg::ALU_AND: alu_out = op_a & op_b;
            rv_core_pkg::ALU_OR:  alu_out = op_a | op_b;
            rv_core_pkg::ALU_XOR: alu_out = op_a ^ op_b;
            rv_core_pkg::ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_core_pkg::ALU_SLL: alu_out = op_a << shamt;
            rv_core_pkg::ALU_SRL: alu_out = op_a >> shamt;
            rv_core_pkg::ALU_SRA: alu_out = $unsigned($signed(op_a) >>> shamt);
            default:              alu_out = op_a + op_b; // add, also load/store address
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
            rd_q   <= '0;
        end else if (!i_dcache_stall) begin
            ctrl_q <= i_id_ex.ctrl;
            rd_q   <= i_id_ex.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_dcache_stall) begin
            alu_q   <= alu_out;
            store_q <= rs2_fwd;
        end
    end

    assign o_ex_mem = '{ctrl: ctrl_q, rd: rd_q, alu_result: alu_q, store_data: store_q};

endmodule

`default_nettype wire

//--- verilog/rv_memory.sv
`timescale 1ns/10ps
`default_nettype none

module rv_memory (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire rv_core_pkg::ex_mem_t                i_ex_mem,
    input  wire logic [rv_core_pkg::XLEN-1:0]        i_dcache_rdata,
    input  wire logic                                i_dcache_stall,
    output      logic                                o_dcache_ren,
    output      logic                                o_dcache_wen,
    output      logic [rv_core_pkg::WORD_ADDR_W-1:0] o_dcache_addr,
    output      logic [rv_core_pkg::XLEN-1:0]        o_dcache_wdata,
    output      rv_core_pkg::wb_t                    o_wb
);

    rv_core_pkg::mem_wb_t mem_wb;

    // request straight from EX/MEM and held there while the cache stalls
    assign o_dcache_ren   = i_ex_mem.ctrl.memread;
    assign o_dcache_wen   = i_ex_mem.ctrl.memwrite;
    assign o_dcache_addr  = i_ex_mem.alu_result[rv_core_pkg::XLEN-1:2];
    assign o_dcache_wdata = rv_core_pkg::byte_swap(i_ex_mem.store_data);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else if (!i_dcache_stall) begin
            mem_wb.regwrite   <= i_ex_mem.ctrl.regwrite;
            mem_wb.memtoreg   <= i_ex_mem.ctrl.memtoreg;
            mem_wb.rd         <= i_ex_mem.rd;
            mem_wb.alu_result <= i_ex_mem.alu_result;
            mem_wb.load_data  <= rv_core_pkg::byte_swap(i_dcache_rdata);
        end
    end

    // writeback select
    assign o_wb.regwrite = mem_wb.regwrite;
    assign o_wb.rd       = mem_wb.rd;
    assign o_wb.data     = mem_wb.memtoreg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    // instruction cache
    output      logic                                o_icache_ren,
    output      logic [rv_core_pkg::WORD_ADDR_W-1:0] o_icache_addr,
    input  wire logic [rv_core_pkg::XLEN-1:0]        i_icache_rdata,
    input  wire logic                                i_icache_stall,
    // data cache
    output      logic                                o_dcache_ren,
    output      logic                                o_dcache_wen,
    output      logic [rv_core_pkg::WORD_ADDR_W-1:0] o_dcache_addr,
    output      logic [rv_core_pkg::XLEN-1:0]        o_dcache_wdata,
    input  wire logic [rv_core_pkg::XLEN-1:0]        i_dcache_rdata,
    input  wire logic                                i_dcache_stall,
    output      logic [rv_core_pkg::XLEN-1:0]        o_pc
);

    logic [rv_core_pkg::XLEN-1:0] if_id_inst;
    logic                         load_use;
    rv_core_pkg::id_ex_t          id_ex;
    rv_core_pkg::ex_mem_t         ex_mem;
    rv_core_pkg::wb_t             wb;

    assign o_icache_ren = 1'b1; // fetch reads every cycle

    rv_fetch u_rv_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_icache_rdata (i_icache_rdata),
        .i_icache_stall (i_icache_stall),
        .i_dcache_stall (i_dcache_stall),
        .i_load_use     (load_use),
        .o_icache_addr  (o_icache_addr),
        .o_pc           (o_pc),
        .o_inst         (if_id_inst)
    );

    rv_decode u_rv_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_inst         (if_id_inst),
        .i_wb           (wb),
        .i_dcache_stall (i_dcache_stall),
        .o_id_ex        (id_ex),
        .o_load_use     (load_use)
    );

    rv_execute u_rv_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_id_ex        (id_ex),
        .i_wb           (wb),
        .i_dcache_stall (i_dcache_stall),
        .o_ex_mem       (ex_mem)
    );

    rv_memory u_rv_memory (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_ex_mem       (ex_mem),
        .i_dcache_rdata (i_dcache_rdata),
        .i_dcache_stall (i_dcache_stall),
        .o_dcache_ren   (o_dcache_ren),
        .o_dcache_wen   (o_dcache_wen),
        .o_dcache_addr  (o_dcache_addr),
        .o_dcache_wdata (o_dcache_wdata),
        .o_wb           (wb)
    );

endmodule

`default_nettype wire

//--- tests/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

    localparam int          MEM_WORDS     = 64;
    localparam int          STORE_TIMEOUT = 200;  // cycles allowed per store
    localparam int          DRAIN_CYCLES  = 40;
    localparam logic [31:0] SEED          = 32'hb221_9827;
    localparam logic [31:0] NOP_WORD      = 32'h0000_0013; // addi x0,x0,0
    localparam string       VEC_FILE      = "tests/rv_core_vectors.txt";

    logic                                clk;
    logic                                rst_n;
    logic                                icache_ren;
    logic [rv_core_pkg::WORD_ADDR_W-1:0] icache_addr;
    logic [31:0]                         icache_rdata;
    logic                                icache_stall;
    logic                                dcache_ren;
    logic                                dcache_wen;
    logic [rv_core_pkg::WORD_ADDR_W-1:0] dcache_addr;
    logic [31:0]                         dcache_wdata;
    logic [31:0]                         dcache_rdata;
    logic                                dcache_stall;
    logic [31:0]                         pc;

    logic [31:0] imem [MEM_WORDS];  // held in port byte order
    logic [31:0] dmem [MEM_WORDS];
    int          n_inst;
    logic [29:0] exp_addr [$];
    logic [31:0] exp_data [$];

    // outputs seen at the previous falling edge
    logic        dstall_prev;
    logic [31:0] snap_pc;
    logic [29:0] snap_iaddr;
    logic        snap_ren;
    logic        snap_wen;
    logic [29:0] snap_addr;
    logic [31:0] snap_wdata;

    rv_core u_rv_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .o_icache_ren   (icache_ren),
        .o_icache_addr  (icache_addr),
        .i_icache_rdata (icache_rdata),
        .i_icache_stall (icache_stall),
        .o_dcache_ren   (dcache_ren),
        .o_dcache_wen   (dcache_wen),
        .o_dcache_addr  (dcache_addr),
        .o_dcache_wdata (dcache_wdata),
        .i_dcache_rdata (dcache_rdata),
        .i_dcache_stall (dcache_stall),
        .o_pc           (pc)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // untouched data words differ for every address
    function automatic logic [31:0] fill_word(input logic [29:0] a);
        return {a, 2'b00} ^ 32'h5ac3_3ca5;
    endfunction

    // cache models answer in the same cycle and only to a read
    assign icache_rdata = !icache_ren ? 32'bx :
                          (icache_addr < n_inst) ? imem[icache_addr[5:0]] :
                          swap_bytes(NOP_WORD);
    assign dcache_rdata = !dcache_ren ? 32'bx :
                          (dcache_addr < MEM_WORDS) ? dmem[dcache_addr[5:0]] :
                          fill_word(dcache_addr);

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [31:0] a;
        logic [31:0] v;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the vector file tests/rv_core_vectors.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%c %h %h", tag, a, v);
            if (n == 3) begin
                if (a >= MEM_WORDS && tag != "S") begin
                    abort_run($sformatf("vector address 0x%h is outside the memory model", a));
                end
                case (tag)
                    "I": begin
                        imem[a[5:0]] = swap_bytes(v);
                        if (a + 1 > n_inst) begin
                            n_inst = a + 1;
                        end
                    end
                    "D": dmem[a[5:0]] = v;
                    "S": begin
                        exp_addr.push_back(a[29:0]);
                        exp_data.push_back(v);
                    end
                    default: abort_run($sformatf("unknown vector line: %s", line));
                endcase
            end
        end
        $fclose(fd);
    endtask

    // one clock of the environment right after a falling edge
    task automatic run_cycle(output logic stored, output logic [29:0] addr,
                             output logic [31:0] data);
        if (dstall_prev) begin  // a stalled cycle must leave the port alone
            check_eq("o_pc", pc, snap_pc);
            check_eq("o_icache_addr", icache_addr, snap_iaddr);
            check_eq("o_dcache_ren", dcache_ren, snap_ren);
            check_eq("o_dcache_wen", dcache_wen, snap_wen);
            check_eq("o_dcache_addr", dcache_addr, snap_addr);
            check_eq("o_dcache_wdata", dcache_wdata, snap_wdata);
        end
        snap_pc    = pc;
        snap_iaddr = icache_addr;
        snap_ren   = dcache_ren;
        snap_wen   = dcache_wen;
        snap_addr  = dcache_addr;
        snap_wdata = dcache_wdata;

        icache_stall = ($urandom % 4) == 0;  // about one cycle in four
        dcache_stall = ($urandom % 4) == 0;
        dstall_prev  = dcache_stall;

        // a store completes at the next rising edge unless stalled
        stored = dcache_wen && !dcache_stall;
        addr   = dcache_addr;
        data   = dcache_wdata;
        if (stored && addr < MEM_WORDS) begin
            dmem[addr[5:0]] = data;
        end
    endtask

    task automatic expect_store(input int idx);
        logic        stored;
        logic [29:0] addr;
        logic [31:0] data;
        int          cycles;
        stored = 1'b0;
        cycles = 0;
        while (!stored && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            run_cycle(stored, addr, data);
            cycles++;
        end
        if (!stored) begin
            abort_run($sformatf("timeout: store %0d to word 0x%h never arrived",
                                idx, exp_addr[idx]));
        end else begin
            check_eq("o_dcache_addr", addr, exp_addr[idx]);
            check_eq("o_dcache_wdata", data, exp_data[idx]);
        end
    endtask

    initial begin
        logic        stored;
        logic        extra;
        logic [29:0] addr;
        logic [31:0] data;

        clk          = 1'b0;
        rst_n        = 1'b0;
        icache_stall = 1'b0;
        dcache_stall = 1'b0;
        dstall_prev  = 1'b0;
        n_inst       = 0;
        extra        = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = swap_bytes(NOP_WORD);
            dmem[i] = fill_word(i);
        end
        load_vectors();

        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // nothing has reached the memory stage yet
        check_eq("o_pc", pc, 32'd0);
        check_eq("o_icache_addr", icache_addr, 32'd0);
        check_eq("o_dcache_ren", dcache_ren, 32'd0);
        check_eq("o_dcache_wen", dcache_wen, 32'd0);

        for (int i = 0; i < exp_addr.size(); i++) begin
            expect_store(i);
        end

        // past the program only NOPs run so no store may follow
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            @(negedge clk);
            run_cycle(stored, addr, data);
            if (stored) begin
                extra = 1'b1;
            end
        end

        if (extra) begin
            abort_run("a store appeared after the last expected one");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/rv_core_vectors.txt
// I: word address, instruction | D: word address, initial memory word as on the port
// S: expected store word address and data as on the port, in program order
I 00 00500093 // addi x1,x0,5
I 01 00708113 // addi x2,x1,7
I 02 002081B3 // add  x3,x1,x2
I 03 08302023 // sw   x3,0x80(x0)
I 04 40118233 // sub  x4,x3,x1
I 05 08402223 // sw   x4,0x84(x0)
I 06 003242B3 // xor  x5,x4,x3
I 07 00129333 // sll  x6,x5,x1
I 08 08602423 // sw   x6,0x88(x0)
I 09 FF000393 // addi x7,x0,-16
I 0A 4013D433 // sra  x8,x7,x1
I 0B 0013D4B3 // srl  x9,x7,x1
I 0C 0013A533 // slt  x10,x7,x1
I 0D 08802623 // sw   x8,0x8c(x0)
I 0E 08902823 // sw   x9,0x90(x0)
I 0F 006565B3 // or   x11,x10,x6
I 10 0095F633 // and  x12,x11,x9
I 11 08C02A23 // sw   x12,0x94(x0)
I 12 04002703 // lw   x14,0x40(x0)
I 13 001707B3 // add  x15,x14,x1
I 14 08F02C23 // sw   x15,0x98(x0)
I 15 04402803 // lw   x16,0x44(x0)
I 16 09002E23 // sw   x16,0x9c(x0)
I 17 4023D893 // srai x17,x7,2
I 18 0B102023 // sw   x17,0xa0(x0)
D 10 78563412 // register value 0x12345678
D 11 A1B2C3D4 // register value 0xd4c3b2a1
S 20 11000000 // x3  = 0x00000011
S 21 0C000000 // x4  = 0x0000000c
S 22 A0030000 // x6  = 0x000003a0
S 23 FFFFFFFF // x8  = 0xffffffff
S 24 FFFFFF07 // x9  = 0x07ffffff
S 25 A1030000 // x12 = 0x000003a1
S 26 7D563412 // x15 = 0x1234567d
S 27 A1B2C3D4 // x16 stored back unchanged
S 28 FCFFFFFF // x17 = 0xfffffffc

//--- sim.f
verilog/rv_core_pkg.sv
verilog/rv_regfile.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_memory.sv
verilog/rv_core.sv
tests/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_core_pkg.sv
  - verilog/rv_regfile.sv
  - verilog/rv_fetch.sv
  - verilog/rv_decode.sv
  - verilog/rv_execute.sv
  - verilog/rv_memory.sv
  - verilog/rv_core.sv
  - target: simulation
    files:
      - tests/tb_rv_core.sv
